//--- hw/calc_defines.svh
`ifndef CALC_DEFINES_SVH
`define CALC_DEFINES_SVH

// Operand, result and display width
`define CALC_W 16

// Keypad code width, legal digits are 0 to 9
`define DIGIT_W 4

// One-hot operator key: 001 add, 010 subtract, 100 multiply
`define OPKEY_W 3

// One multiplier bit per step
`define MUL_STEPS `CALC_W

`endif

//--- hw/calc_pkg.sv
`include "calc_defines.svh"

package calc_pkg;

    // Operation latched from the operator key
    typedef enum logic [1:0] {
        OP_ADD = 2'd0,                  // a + b
        OP_SUB = 2'd1,                  // a - b, wraps
        OP_MUL = 2'd2                   // Low half of a * b
    } calc_op_t;

    // Sequencer states
    typedef enum logic [2:0] {
        ENTER_FIRST  = 3'd0,            // Digits go to operand a
        ENTER_SECOND = 3'd1,            // Digits go to operand b
        DISPATCH     = 3'd2,            // Start pulse to one unit
        WAIT_EXEC    = 3'd3,            // Waiting on finish
        SHOW         = 3'd4             // Result captured, operands cleared
    } calc_state_t;

    // Request bundle to both execute units
    typedef struct packed {
        calc_op_t            op;        // Selects add or subtract
        logic [`CALC_W-1:0]  a;         // First operand
        logic [`CALC_W-1:0]  b;         // Second operand
    } exec_req_t;

endpackage

//--- hw/operand_entry.sv
`timescale 1ns/1ps
`include "calc_defines.svh"

module operand_entry
    import calc_pkg::*;
(
    input  logic                clk,
    input  logic                nRST,
    input  logic [`DIGIT_W-1:0] keypad_input,   // Raw keypad code
    input  logic                read_input,     // Keypad code valid this cycle
    input  logic [`OPKEY_W-1:0] operator_input, // One-hot operator key
    input  logic                second_sel,     // High outside first-operand entry
    input  logic                entry_clear,    // Zero both operands
    output logic [`CALC_W-1:0]  operand_a,
    output logic [`CALC_W-1:0]  operand_b,
    output calc_op_t            op,             // Latched operation
    output logic                op_valid,       // Legal key seen in first phase
    output logic                digit_taken     // Digit accumulated this cycle
);

    logic               digit_legal;    // Codes 10 to 15 rejected
    logic [`CALC_W-1:0] digit_ext;      // Digit zero-extended to data width
    logic [`CALC_W-1:0] acc_src;        // Operand being extended
    logic [`CALC_W-1:0] acc_next;       // acc_src * 10 + digit, mod 2^16
    logic               key_onehot;
    calc_op_t           key_op;

    assign digit_legal = read_input && (keypad_input <= `DIGIT_W'd9);
    assign digit_taken = digit_legal && !entry_clear;   // Clear wins over a digit
    assign digit_ext   = {{(`CALC_W-`DIGIT_W){1'b0}}, keypad_input};
    assign acc_src     = second_sel ? operand_b : operand_a;
    assign acc_next    = (acc_src << 3) + (acc_src << 1) + digit_ext;  // x*8 + x*2

    // Operator key decode, anything not one-hot is dropped
    always_comb begin
        key_onehot = 1'b1;
        key_op     = OP_ADD;
        case (operator_input)
            3'b001:  key_op = OP_ADD;
            3'b010:  key_op = OP_SUB;
            3'b100:  key_op = OP_MUL;
            default: key_onehot = 1'b0;
        endcase
    end

    // Only honoured in the first phase, so a held key gives a single pulse
    assign op_valid = key_onehot && !second_sel;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            operand_a <= '0;
            operand_b <= '0;
            op        <= OP_ADD;
        end else begin
            if (entry_clear) begin
                operand_a <= '0;            // Fresh start for next calculation
                operand_b <= '0;
            end else if (digit_legal) begin
                if (second_sel)
                    operand_b <= acc_next;
                else
                    operand_a <= acc_next;
            end
            if (op_valid)
                op <= key_op;               // Held through dispatch
        end
    end

    // Accepted operator moves the sequencer to second-operand entry next cycle
    a_op_phase: assert property (@(posedge clk) disable iff (!nRST)
        op_valid |=> second_sel);

endmodule

//--- hw/add_sub_unit.sv
`timescale 1ns/1ps
`include "calc_defines.svh"

module add_sub_unit
    import calc_pkg::*;
(
    input  logic               clk,
    input  logic               nRST,
    input  exec_req_t          exec_req,   // Sampled only on start
    input  logic               start,      // One-cycle request pulse
    output logic [`CALC_W-1:0] result,
    output logic               finish      // One-cycle done pulse
);

    logic [`CALC_W-1:0] sum;
    logic [`CALC_W-1:0] diff;

    assign sum  = exec_req.a + exec_req.b;
    assign diff = exec_req.a - exec_req.b;     // Wraps when b > a

    // Done flag trails start by one edge
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST)
            finish <= 1'b0;
        else
            finish <= start;
    end

    // Result register, loaded with the request
    always_ff @(posedge clk) begin
        if (start)
            result <= (exec_req.op == OP_ADD) ? sum : diff;
    end

    // Multiply requests belong to the other unit
    a_no_mul: assert property (@(posedge clk) disable iff (!nRST)
        start |-> (exec_req.op != OP_MUL));

endmodule

//--- hw/shift_add_multiplier.sv
`timescale 1ns/1ps
`include "calc_defines.svh"

module shift_add_multiplier
    import calc_pkg::*;
(
    input  logic               clk,
    input  logic               nRST,
    input  exec_req_t          exec_req,   // a is multiplicand, b is multiplier
    input  logic               start,      // One-cycle request pulse
    output logic [`CALC_W-1:0] result,     // Low 16 bits of a * b
    output logic               finish      // MUL_STEPS cycles after start
);

    localparam int unsigned CNT_W = $clog2(`MUL_STEPS);
    localparam logic [CNT_W-1:0] LAST_LOAD = CNT_W'(`MUL_STEPS - 1);  // Bit 0 done at load

    logic               busy;
    logic [CNT_W-1:0]   count;     // Steps still to run
    logic [`CALC_W-1:0] mcand;     // Shifted multiplicand, upper bits fall off
    logic [`CALC_W-1:0] mplier;    // Remaining multiplier bits, LSB first
    logic [`CALC_W-1:0] acc;       // Partial product

    // Step counter and handshake
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy   <= 1'b0;
            count  <= '0;
            finish <= 1'b0;
        end else begin
            finish <= 1'b0;
            if (start) begin
                busy  <= 1'b1;
                count <= LAST_LOAD;
            end else if (busy) begin
                count <= count - 1'b1;
                if (count == CNT_W'(1)) begin
                    busy   <= 1'b0;     // Last bit handled this edge
                    finish <= 1'b1;
                end
            end
        end
    end

    // Datapath, first multiplier bit folded into the load
    always_ff @(posedge clk) begin
        if (start) begin
            acc    <= exec_req.b[0] ? exec_req.a : '0;
            mcand  <= exec_req.a << 1;
            mplier <= exec_req.b >> 1;
        end else if (busy) begin
            if (mplier[0])
                acc <= acc + mcand;     // Mod 2^16 add
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign result = acc;                // Holds until next start

    // No new request while iterating
    a_no_overlap: assert property (@(posedge clk) disable iff (!nRST)
        start |-> !busy);

endmodule

//--- hw/calc_controller.sv
`timescale 1ns/1ps
`include "calc_defines.svh"

module calc_controller
    import calc_pkg::*;
(
    input  logic               clk,
    input  logic               nRST,
    input  logic               equal_input,    // Evaluate key
    input  calc_op_t           op,             // Latched operation
    input  logic               op_valid,       // Operator accepted
    input  logic               digit_taken,    // Digit accumulated
    input  logic [`CALC_W-1:0] operand_a,
    input  logic [`CALC_W-1:0] operand_b,
    input  logic [`CALC_W-1:0] add_result,
    input  logic               add_finish,
    input  logic [`CALC_W-1:0] mul_result,
    input  logic               mul_finish,
    output logic               second_sel,     // Entry phase to operand_entry
    output logic               entry_clear,    // Operand wipe after a result
    output exec_req_t          exec_req,       // Shared request to both units
    output logic               add_start,
    output logic               mul_start,
    output logic               complete,       // Result valid flag
    output logic [`CALC_W-1:0] display_output  // Last result
);

    calc_state_t state, next_state;
    logic        exec_done;        // Finish from whichever unit ran

    assign exec_done = add_finish || mul_finish;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST)
            state <= ENTER_FIRST;
        else
            state <= next_state;
    end

    // Next state
    always_comb begin
        next_state = state;
        case (state)
            ENTER_FIRST: begin
                if (op_valid)
                    next_state = ENTER_SECOND;
            end
            ENTER_SECOND: begin
                if (equal_input)            // Operators ignored here
                    next_state = DISPATCH;
            end
            DISPATCH:
                next_state = WAIT_EXEC;     // Start pulse goes out this cycle
            WAIT_EXEC: begin
                if (exec_done)
                    next_state = SHOW;
            end
            SHOW:
                next_state = ENTER_FIRST;
            default:
                next_state = ENTER_FIRST;
        endcase
    end

    // Phase and clear to the entry stage
    assign second_sel  = (state != ENTER_FIRST);   // Also blocks operators past entry
    assign entry_clear = (state == SHOW);

    // Request packing and unit select
    assign exec_req.op = op;
    assign exec_req.a  = operand_a;
    assign exec_req.b  = operand_b;
    assign add_start   = (state == DISPATCH) && (op != OP_MUL);
    assign mul_start   = (state == DISPATCH) && (op == OP_MUL);

    // Result capture and completion flag
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            complete       <= 1'b0;
            display_output <= '0;
        end else if (state == WAIT_EXEC && add_finish) begin
            complete       <= 1'b1;
            display_output <= add_result;
        end else if (state == WAIT_EXEC && mul_finish) begin
            complete       <= 1'b1;
            display_output <= mul_result;
        end else if (state == ENTER_FIRST && digit_taken) begin
            complete       <= 1'b0;         // Display keeps old value
        end
    end

    // Unit answers only while the sequencer is waiting for it
    a_finish_in_wait: assert property (@(posedge clk) disable iff (!nRST)
        exec_done |-> (state == WAIT_EXEC));

    // Multiplier answers after exactly MUL_STEPS cycles
    a_mul_latency: assert property (@(posedge clk) disable iff (!nRST)
        mul_start |-> ##(`MUL_STEPS) mul_finish);

endmodule

//--- hw/calc_top.sv
`timescale 1ns/1ps
`include "calc_defines.svh"

module calc_top
    import calc_pkg::*;
(
    input  logic                clk,
    input  logic                nRST,
    input  logic [`DIGIT_W-1:0] keypad_input,
    input  logic                read_input,
    input  logic [`OPKEY_W-1:0] operator_input,
    input  logic                equal_input,
    output logic                complete,
    output logic [`CALC_W-1:0]  display_output
);

    logic [`CALC_W-1:0] operand_a, operand_b;
    calc_op_t           op;
    logic               op_valid, digit_taken;
    logic               second_sel, entry_clear;
    exec_req_t          exec_req;
    logic               add_start, mul_start;
    logic [`CALC_W-1:0] add_result, mul_result;
    logic               add_finish, mul_finish;

    // Decode stage
    operand_entry u_operand_entry (
        .clk, .nRST, .keypad_input, .read_input, .operator_input,
        .second_sel, .entry_clear, .operand_a, .operand_b,
        .op, .op_valid, .digit_taken
    );

    // Sequencer and result register
    calc_controller u_calc_controller (
        .clk, .nRST, .equal_input, .op, .op_valid, .digit_taken,
        .operand_a, .operand_b, .add_result, .add_finish,
        .mul_result, .mul_finish, .second_sel, .entry_clear,
        .exec_req, .add_start, .mul_start, .complete, .display_output
    );

    add_sub_unit u_add_sub_unit (
        .clk, .nRST, .exec_req, .start(add_start),
        .result(add_result), .finish(add_finish)
    );

    shift_add_multiplier u_shift_add_multiplier (
        .clk, .nRST, .exec_req, .start(mul_start),
        .result(mul_result), .finish(mul_finish)
    );

endmodule

//--- testbench/calc_tb.sv
`timescale 1ns/1ps
`include "calc_defines.svh"

module calc_tb;

    logic                clk;
    logic                nRST;
    logic [`DIGIT_W-1:0] keypad_input;
    logic                read_input;
    logic [`OPKEY_W-1:0] operator_input;
    logic                equal_input;
    logic                complete;
    logic [`CALC_W-1:0]  display_output;

    int unsigned        errors;
    int unsigned        checks;
    bit                 timed_out;       // Stops further sessions
    bit                 have_result;     // Earlier session left a result up
    logic [`CALC_W-1:0] last_display;    // Model value of that result
    int                 s;

    calc_top u_calc_top (
        .clk, .nRST, .keypad_input, .read_input, .operator_input,
        .equal_input, .complete, .display_output
    );

    always #4 clk = ~clk;                // 8 ns period

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("ERR %s expected %0d actual %0d", name, expected, actual);
        end
    endtask

    task automatic release_keys();
        keypad_input   = '0;
        read_input     = 1'b0;
        operator_input = '0;
        equal_input    = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // One key per cycle, released on the next falling edge
    task automatic press_digit(input logic [`DIGIT_W-1:0] d);
        keypad_input = d;
        read_input   = 1'b1;
        @(negedge clk);
        release_keys();
    endtask

    task automatic press_operator(input logic [`OPKEY_W-1:0] key);
        operator_input = key;
        @(negedge clk);
        release_keys();
    endtask

    // Keys the core must drop
    task automatic press_junk(input bit second_phase);
        int unsigned kind;
        kind = $urandom % (second_phase ? 3 : 2);
        case (kind)
            0: begin
                keypad_input = `DIGIT_W'(10 + $urandom % 6);     // Codes 10 to 15
                read_input   = 1'b1;
            end
            1: operator_input = 3'b111 ^ (3'b001 << ($urandom % 4)); // Multi-hot
            default: operator_input = 3'b001 << ($urandom % 3);      // Extra operator in b
        endcase
        @(negedge clk);
        release_keys();
    endtask

    // Types 1 to 5 digits, or always 5, and builds the model operand alongside
    task automatic enter_operand(input bit second_phase, input bit five_digits,
                                 output logic [`CALC_W-1:0] value);
        int unsigned         n;
        int unsigned         i;
        logic [`DIGIT_W-1:0] d;
        n     = five_digits ? 5 : 1 + $urandom % 5;
        value = '0;
        for (i = 0; i < n; i++) begin
            if (i > 0 && ($urandom % 4) == 0)
                press_junk(second_phase);
            idle_cycles($urandom % 3);
            d = `DIGIT_W'($urandom % 10);
            press_digit(d);
            value = value * `CALC_W'd10 + `CALC_W'(d);      // Wraps mod 2^16
            if (!second_phase && i == 0 && have_result) begin
                check("clear_complete", 0, complete);       // First digit drops the flag
                check("clear_display", last_display, display_output);
            end
        end
    endtask

    // Presses equal, then counts edges until complete, with traffic meanwhile
    task automatic wait_result(output int cycles);
        bit done;
        done        = 1'b0;
        cycles      = 0;
        equal_input = 1'b1;
        while (!done && cycles < 40) begin
            @(negedge clk);
            release_keys();
            cycles++;
            if (complete) begin
                done = 1'b1;
            end else begin
                keypad_input   = `DIGIT_W'($urandom % 16);  // Ignored while busy
                read_input     = 1'($urandom % 2);
                operator_input = `OPKEY_W'($urandom % 8);
                equal_input    = 1'($urandom % 2);
            end
        end
        if (!done) begin
            $display("Timeout: complete did not rise within 40 cycles after equal");
            errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic run_session();
        logic [`CALC_W-1:0] a;
        logic [`CALC_W-1:0] b;
        logic [`CALC_W-1:0] expected;
        logic [31:0]        prod;
        int unsigned        sel;
        int                 cycles;
        string              name;
        sel = $urandom % 3;                                  // add, sub, mul
        enter_operand(1'b0, sel == 0, a);                    // Full-size addends
        if (($urandom % 3) == 0)
            press_junk(1'b0);
        idle_cycles($urandom % 3);
        press_operator(3'b001 << sel);
        if (($urandom % 3) == 0)
            press_junk(1'b1);
        enter_operand(1'b1, sel == 0, b);
        idle_cycles($urandom % 3);
        prod = {16'd0, a} * {16'd0, b};
        case (sel)
            0: begin
                expected = a + b;
                name     = "add";
            end
            1: begin
                expected = a - b;                            // Wraps when b > a
                name     = "sub";
            end
            default: begin
                expected = prod[`CALC_W-1:0];
                name     = "mul";
            end
        endcase
        wait_result(cycles);
        if (!timed_out) begin
            check(name, expected, display_output);
            check({name, "_latency"}, (sel == 2) ? 18 : 3, cycles);
            repeat (1 + $urandom % 4) begin                  // Result must hold
                @(negedge clk);
                check("hold_complete", 1, complete);
                check("hold_display", expected, display_output);
            end
            last_display = expected;
            have_result  = 1'b1;
        end
    endtask

    initial begin
        void'($urandom(8937));
        clk          = 1'b0;
        nRST         = 1'b0;
        errors       = 0;
        checks       = 0;
        timed_out    = 1'b0;
        have_result  = 1'b0;
        last_display = '0;
        release_keys();
        repeat (5) @(negedge clk);                           // 5 cycles in reset
        nRST = 1'b1;
        check("reset_complete", 0, complete);
        check("reset_display", 0, display_output);
        @(negedge clk);
        check("reset_complete", 0, complete);
        check("reset_display", 0, display_output);
        for (s = 0; s < 60 && !timed_out; s++)
            run_session();
        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

//--- build.f
+incdir+hw
hw/calc_pkg.sv
hw/operand_entry.sv
hw/add_sub_unit.sv
hw/shift_add_multiplier.sv
hw/calc_controller.sv
hw/calc_top.sv
testbench/calc_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile the calculator testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f --top-module calc_tb \
    -o calc_sim > build.log 2>&1 ||
    { echo "Build failed, see build.log"; exit 1; }

./obj_dir/calc_sim > sim.log 2>&1 ||
    { cat sim.log; echo "Simulation exited with an error"; exit 1; }

cat sim.log
grep -q "Verification failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
